//--- rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// --------------------
// Register file sizes
// --------------------

// MIPS architectural registers, r0 is $zero
`define RN_NUM_ARCH 32
`define RN_NUM_PHYS 64

`define RN_ARCH_BITS 5
`define RN_PHYS_BITS 6

// --------------------
// Operation fields
// --------------------

// Reorder tag wraps around
`define RN_TAG_BITS 6
`define RN_ALU_BITS 6

// --------------------
// Queue depths
// --------------------

`define RN_DECODE_DEPTH 8
`define RN_LSQ_DEPTH 16

`endif

//--- regPkg.sv
`include "rename_settings.svh"

package regPkg;

    // --------------------
    // Register naming
    // --------------------

    // Architectural register index, index 0 is $zero
    typedef logic [`RN_ARCH_BITS-1:0] archReg_t;

    // Physical register index
    typedef logic [`RN_PHYS_BITS-1:0] physReg_t;

    // --------------------
    // Ordering and control
    // --------------------

    // Reorder tag, one per renamed operation, wraps at the top
    typedef logic [`RN_TAG_BITS-1:0] robTag_t;

    // ALU control code as produced by decode
    typedef logic [`RN_ALU_BITS-1:0] aluCtrl_t;

endpackage

//--- uopPkg.sv
`include "rename_settings.svh"

package uopPkg;

    import regPkg::*;

    // --------------------
    // Decode to rename
    // --------------------

    // Operation as it leaves decode
    typedef struct packed {
        archReg_t   srcA;
        archReg_t   srcB;
        archReg_t   dst;
        logic       regWrite;
        logic       isMem;
        aluCtrl_t   aluCtrl;
        logic [4:0] shamt;
    } decodedOp_t;

    // --------------------
    // Rename to back end
    // --------------------

    // Operation after rename, with physical names and its reorder tag
    // oldDst is released by the ROB once this operation retires
    typedef struct packed {
        physReg_t srcA;
        physReg_t srcB;
        physReg_t dst;
        physReg_t oldDst;
        logic     regWrite;
        logic     isMem;
        aluCtrl_t aluCtrl;
        robTag_t  tag;
    } renamedOp_t;

endpackage

//--- opQueue.sv
`timescale 1ns/10ps
`include "rename_settings.svh"

module opQueue #(
    parameter int  DEPTH = `RN_DECODE_DEPTH,
    parameter type itemT = logic [7:0]
) (
    input  logic CLK,
    input  logic arstN,

    // Write side
    input  itemT inItem,
    input  logic inValid,
    output logic inReady,

    // Read side, head of the queue
    output itemT outItem,
    output logic outValid,
    input  logic outReady
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_BITS-1:0] LAST_IDX = PTR_BITS'(DEPTH - 1);
    localparam logic [PTR_BITS:0] FULL_COUNT = (PTR_BITS + 1)'(DEPTH);

    itemT mem [DEPTH];

    logic [PTR_BITS-1:0] rdPtr;
    logic [PTR_BITS-1:0] wrPtr;
    logic [PTR_BITS:0]   count;
    logic                push;
    logic                pop;

    // --------------------
    // Handshake
    // --------------------

    assign outValid = (count != '0);
    assign outItem  = mem[rdPtr];
    assign pop      = outValid && outReady;

    // A full queue still takes a push when the head leaves this cycle
    assign inReady = (count != FULL_COUNT) || outReady;
    assign push    = inValid && inReady;

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wrPtr] <= inItem;
        end
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == LAST_IDX) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == LAST_IDX) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- freeList.sv
`timescale 1ns/10ps
`include "rename_settings.svh"

module freeList import regPkg::*; (
    input  logic     CLK,
    input  logic     arstN,

    // Allocation from the head
    input  logic     alloc,
    output physReg_t allocReg,
    output logic     available,

    // Registers returned at retire
    input  logic     retValid,
    input  physReg_t retReg
);

    // One slot per physical register, so the list never overflows
    physReg_t store [`RN_NUM_PHYS];

    logic [`RN_PHYS_BITS-1:0] headPtr;
    logic [`RN_PHYS_BITS-1:0] tailPtr;
    logic [`RN_PHYS_BITS:0]   count;
    logic                     doAlloc;

    assign available = (count != '0);
    assign allocReg  = store[headPtr];

    // Guard against a request on an empty list
    assign doAlloc = alloc && available;

    // --------------------
    // List state
    // --------------------

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            // Registers above the architectural range start out free
            for (int i = 0; i < `RN_NUM_PHYS; i++) begin
                store[i] <= physReg_t'(i + `RN_NUM_ARCH);
            end
            headPtr <= '0;
            tailPtr <= (`RN_PHYS_BITS)'(`RN_NUM_ARCH);
            count   <= (`RN_PHYS_BITS + 1)'(`RN_NUM_PHYS - `RN_NUM_ARCH);
        end else begin
            // Returned registers queue up behind the ones already free
            if (retValid) begin
                store[tailPtr] <= retReg;
                tailPtr        <= tailPtr + 1'b1;
            end
            if (doAlloc) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({retValid, doAlloc})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- frat.sv
`timescale 1ns/10ps
`include "rename_settings.svh"

module frat import regPkg::*; (
    input  logic     CLK,
    input  logic     arstN,

    // Lookups for the operation at the decode queue head
    input  archReg_t rdA,
    input  archReg_t rdB,
    input  archReg_t rdDst,
    output physReg_t mapA,
    output physReg_t mapB,
    output physReg_t mapDst,

    // New mapping from rename
    input  logic     wrEn,
    input  archReg_t wrArch,
    input  physReg_t wrPhys
);

    physReg_t mapTable [`RN_NUM_ARCH];

    // Reads see the table before this cycle's update
    assign mapA   = mapTable[rdA];
    assign mapB   = mapTable[rdB];
    // Previous mapping of the destination, released later as oldDst
    assign mapDst = mapTable[rdDst];

    // --------------------
    // Table update
    // --------------------

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            // Identity mapping out of reset
            for (int i = 0; i < `RN_NUM_ARCH; i++) begin
                mapTable[i] <= physReg_t'(i);
            end
        end else if (wrEn && (wrArch != '0)) begin
            // $zero keeps physical register 0
            mapTable[wrArch] <= wrPhys;
        end
    end

endmodule

//--- renameCtrl.sv
`timescale 1ns/10ps
`include "rename_settings.svh"

module renameCtrl import regPkg::*, uopPkg::*; (
    input  logic       CLK,
    input  logic       arstN,

    // Decode queue head
    input  decodedOp_t headOp,
    input  logic       headValid,
    output logic       headReady,

    // F-RAT lookups and update enable
    input  physReg_t   mapA,
    input  physReg_t   mapB,
    input  physReg_t   mapDst,
    output logic       fratWrEn,

    // Free list head
    input  physReg_t   freeReg,
    input  logic       freeAvail,
    output logic       freeAlloc,

    // Registered issue port
    output renamedOp_t issueOp,
    output logic       issueValid,
    input  logic       issueReady,

    // Load/store queue push
    output renamedOp_t lsqOp,
    output logic       lsqPush,
    input  logic       lsqReady
);

    robTag_t    tagCount;
    renamedOp_t renamed;
    logic       needAlloc;
    logic       allocStall;
    logic       issueFree;
    logic       targetOk;
    logic       fire;

    // --------------------
    // Stall decision
    // --------------------

    // Writes to $zero take no physical register
    assign needAlloc  = headOp.regWrite && (headOp.dst != '0);
    assign allocStall = needAlloc && !freeAvail;

    // Issue register can be refilled when empty or draining this cycle
    assign issueFree = !issueValid || issueReady;
    assign targetOk  = headOp.isMem ? lsqReady : issueFree;

    assign headReady = !allocStall && targetOk;
    assign fire      = headValid && headReady;

    assign freeAlloc = fire && needAlloc;
    assign fratWrEn  = fire && needAlloc;

    // --------------------
    // Renamed operation
    // --------------------

    always_comb begin
        renamed.srcA     = mapA;
        renamed.srcB     = mapB;
        renamed.dst      = needAlloc ? freeReg : mapDst;
        renamed.oldDst   = mapDst;
        renamed.regWrite = headOp.regWrite;
        renamed.isMem    = headOp.isMem;
        renamed.aluCtrl  = headOp.aluCtrl;
        renamed.tag      = tagCount;
    end

    // Memory operations go straight into the LSQ
    assign lsqOp   = renamed;
    assign lsqPush = fire && headOp.isMem;

    // --------------------
    // Issue register and tags
    // --------------------

    always_ff @(posedge CLK) begin
        if (fire && !headOp.isMem) begin
            issueOp <= renamed;
        end
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            issueValid <= 1'b0;
            tagCount   <= '0;
        end else begin
            if (fire && !headOp.isMem) begin
                issueValid <= 1'b1;
            end else if (issueReady) begin
                issueValid <= 1'b0;
            end
            // One tag per renamed operation, on either port
            if (fire) begin
                tagCount <= tagCount + 1'b1;
            end
        end
    end

endmodule

//--- renameTop.sv
`timescale 1ns/10ps
`include "rename_settings.svh"

module renameTop import regPkg::*, uopPkg::*; (
    input  logic       CLK,
    input  logic       arstN,

    // Decoded operations in
    input  decodedOp_t decodeOp,
    input  logic       decodeValid,
    output logic       decodeReady,

    // Non-memory operations out
    output renamedOp_t issueOp,
    output logic       issueValid,
    input  logic       issueReady,

    // Memory operations out
    output renamedOp_t lsqOp,
    output logic       lsqValid,
    input  logic       lsqReady,

    // Registers freed at retire
    input  logic       retireValid,
    input  physReg_t   retirePhys
);

    // Decode queue head
    decodedOp_t headOp;
    logic       headValid;
    logic       headReady;

    // F-RAT
    physReg_t   mapA;
    physReg_t   mapB;
    physReg_t   mapDst;
    logic       fratWrEn;

    // Free list
    physReg_t   freeReg;
    logic       freeAvail;
    logic       freeAlloc;

    // Rename to LSQ
    renamedOp_t lsqInOp;
    logic       lsqPush;
    logic       lsqInReady;

    // --------------------
    // Decode queue
    // --------------------

    opQueue #(
        .DEPTH (`RN_DECODE_DEPTH),
        .itemT (decodedOp_t)
    ) decodeQueue (
        .CLK      (CLK),
        .arstN    (arstN),
        .inItem   (decodeOp),
        .inValid  (decodeValid),
        .inReady  (decodeReady),
        .outItem  (headOp),
        .outValid (headValid),
        .outReady (headReady)
    );

    // --------------------
    // Rename
    // --------------------

    frat i_frat (
        .CLK    (CLK),
        .arstN  (arstN),
        .rdA    (headOp.srcA),
        .rdB    (headOp.srcB),
        .rdDst  (headOp.dst),
        .mapA   (mapA),
        .mapB   (mapB),
        .mapDst (mapDst),
        .wrEn   (fratWrEn),
        .wrArch (headOp.dst),
        .wrPhys (freeReg)
    );

    freeList i_freeList (
        .CLK       (CLK),
        .arstN     (arstN),
        .alloc     (freeAlloc),
        .allocReg  (freeReg),
        .available (freeAvail),
        .retValid  (retireValid),
        .retReg    (retirePhys)
    );

    renameCtrl i_renameCtrl (
        .CLK        (CLK),
        .arstN      (arstN),
        .headOp     (headOp),
        .headValid  (headValid),
        .headReady  (headReady),
        .mapA       (mapA),
        .mapB       (mapB),
        .mapDst     (mapDst),
        .fratWrEn   (fratWrEn),
        .freeReg    (freeReg),
        .freeAvail  (freeAvail),
        .freeAlloc  (freeAlloc),
        .issueOp    (issueOp),
        .issueValid (issueValid),
        .issueReady (issueReady),
        .lsqOp      (lsqInOp),
        .lsqPush    (lsqPush),
        .lsqReady   (lsqInReady)
    );

    // --------------------
    // Load/store queue
    // --------------------

    opQueue #(
        .DEPTH (`RN_LSQ_DEPTH),
        .itemT (renamedOp_t)
    ) lsq (
        .CLK      (CLK),
        .arstN    (arstN),
        .inItem   (lsqInOp),
        .inValid  (lsqPush),
        .inReady  (lsqInReady),
        .outItem  (lsqOp),
        .outValid (lsqValid),
        .outReady (lsqReady)
    );

endmodule

//--- renameTop_assert.sv
`timescale 1ns/10ps
`include "rename_settings.svh"

module renameTop_assert import regPkg::*, uopPkg::*; (
    input logic       CLK,
    input logic       arstN,
    input renamedOp_t issueOp,
    input logic       issueValid,
    input logic       issueReady,
    input renamedOp_t lsqOp,
    input logic       lsqValid,
    input logic       lsqReady
);

    // --------------------
    // Output handshakes
    // --------------------

    // A raised valid holds with stable data until the transfer
    property holdIssue;
        @(posedge CLK) disable iff (!arstN)
        issueValid && !issueReady |=> issueValid && $stable(issueOp);
    endproperty

    property holdLsq;
        @(posedge CLK) disable iff (!arstN)
        lsqValid && !lsqReady |=> lsqValid && $stable(lsqOp);
    endproperty

    issueHoldCheck: assert property (holdIssue)
        else $error("issue output dropped or changed before issueReady");

    lsqHoldCheck: assert property (holdLsq)
        else $error("load/store output dropped or changed before lsqReady");

    // No output is offered while reset is active
    resetQuietCheck: assert property (@(posedge CLK) !arstN |-> !issueValid && !lsqValid)
        else $error("output valid high during reset");

endmodule

bind renameTop renameTop_assert i_renameTop_assert (.*);

//--- renameTop_tb.sv
`timescale 1ns/10ps
`include "rename_settings.svh"

module renameTop_tb import regPkg::*, uopPkg::*; ();

    localparam int NUM_ROWS   = 8;
    localparam int NUM_FILL   = 28;
    localparam int NUM_RANDOM = 60;
    localparam int WAIT_LIMIT = 3000;

    logic       CLK;
    logic       arstN;
    decodedOp_t decodeOp;
    logic       decodeValid;
    logic       decodeReady;
    renamedOp_t issueOp;
    logic       issueValid;
    logic       issueReady;
    renamedOp_t lsqOp;
    logic       lsqValid;
    logic       lsqReady;
    logic       retireValid;
    physReg_t   retirePhys;

    // Directed rows, expected values worked out by hand
    decodedOp_t tblOp [NUM_ROWS];
    logic       tblMem [NUM_ROWS];
    renamedOp_t tblExp [NUM_ROWS];

    renamedOp_t issueGot[$];
    renamedOp_t lsqGot[$];
    decodedOp_t sentOps[$];
    physReg_t   retirePool[$];
    physReg_t   manualRetire[$];
    physReg_t   retired[$];

    // Reference model state
    physReg_t   modelMap [`RN_NUM_ARCH];
    physReg_t   modelFree[$];
    robTag_t    modelTag;

    logic       randMode;
    int         valueErrors;
    int         otherErrors;
    int         base;
    decodedOp_t rnd;

    renameTop i_renameTop (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        #500000;
        $display("Simulation time limit reached");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // --------------------
    // Output capture
    // --------------------

    always @(posedge CLK) begin
        if (arstN && issueValid && issueReady) begin
            issueGot.push_back(issueOp);
            if (issueOp.regWrite && issueOp.dst != issueOp.oldDst) begin
                retirePool.push_back(issueOp.oldDst);
            end
        end
        if (arstN && lsqValid && lsqReady) begin
            lsqGot.push_back(lsqOp);
            if (lsqOp.regWrite && lsqOp.dst != lsqOp.oldDst) begin
                retirePool.push_back(lsqOp.oldDst);
            end
        end
    end

    // Ready and retire patterns, random or scripted
    always @(negedge CLK) begin
        if (randMode) begin
            issueReady = ($urandom % 3) != 0;
            lsqReady   = ($urandom % 3) != 0;
        end else begin
            issueReady = 1'b1;
            lsqReady   = 1'b1;
        end
        retireValid = 1'b0;
        if (arstN) begin
            if (randMode && retirePool.size() > 0 && ($urandom % 4) == 0) begin
                retirePhys  = retirePool.pop_front();
                retireValid = 1'b1;
            end else if (!randMode && manualRetire.size() > 0) begin
                retirePhys  = manualRetire.pop_front();
                retireValid = 1'b1;
            end
            if (retireValid) begin
                modelFree.push_back(retirePhys);
                retired.push_back(retirePhys);
            end
        end
    end

    // --------------------
    // Helpers
    // --------------------

    function automatic decodedOp_t mkDec(int a, int b, int d, logic rw, logic mem, int alu);
        decodedOp_t op;
        op.srcA     = archReg_t'(a);
        op.srcB     = archReg_t'(b);
        op.dst      = archReg_t'(d);
        op.regWrite = rw;
        op.isMem    = mem;
        op.aluCtrl  = aluCtrl_t'(alu);
        op.shamt    = 5'd0;
        return op;
    endfunction

    function automatic renamedOp_t mkRen(int a, int b, int d, int old, logic rw, logic mem,
                                         int alu, int tag);
        renamedOp_t r;
        r.srcA     = physReg_t'(a);
        r.srcB     = physReg_t'(b);
        r.dst      = physReg_t'(d);
        r.oldDst   = physReg_t'(old);
        r.regWrite = rw;
        r.isMem    = mem;
        r.aluCtrl  = aluCtrl_t'(alu);
        r.tag      = robTag_t'(tag);
        return r;
    endfunction

    // Model: map sources, take the free list head for a nonzero write
    function automatic renamedOp_t modelRename(decodedOp_t op);
        renamedOp_t r;
        r.srcA     = modelMap[op.srcA];
        r.srcB     = modelMap[op.srcB];
        r.oldDst   = modelMap[op.dst];
        r.dst      = r.oldDst;
        r.regWrite = op.regWrite;
        r.isMem    = op.isMem;
        r.aluCtrl  = op.aluCtrl;
        r.tag      = modelTag;
        if (op.regWrite && op.dst != '0) begin
            if (modelFree.size() == 0) begin
                otherErrors++;
                $display("Model free list ran empty");
            end else begin
                r.dst             = modelFree.pop_front();
                modelMap[op.dst] = r.dst;
            end
        end
        modelTag = modelTag + 1'b1;
        return r;
    endfunction

    task automatic setRow(int i, decodedOp_t op, logic mem, renamedOp_t exp);
        tblOp[i]  = op;
        tblMem[i] = mem;
        tblExp[i] = exp;
    endtask

    task automatic checkPhys(string name, physReg_t got, physReg_t exp);
        if (got !== exp) begin
            valueErrors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkTag(string name, robTag_t got, robTag_t exp);
        if (got !== exp) begin
            valueErrors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkOp(string name, renamedOp_t got, renamedOp_t exp);
        checkPhys({name, ".srcA"}, got.srcA, exp.srcA);
        checkPhys({name, ".srcB"}, got.srcB, exp.srcB);
        checkPhys({name, ".dst"}, got.dst, exp.dst);
        checkPhys({name, ".oldDst"}, got.oldDst, exp.oldDst);
        checkTag({name, ".tag"}, got.tag, exp.tag);
        if ({got.regWrite, got.isMem, got.aluCtrl} !== {exp.regWrite, exp.isMem, exp.aluCtrl}) begin
            valueErrors++;
            $display("error %s.ctrl got %h expected %h", name,
                     {got.regWrite, got.isMem, got.aluCtrl},
                     {exp.regWrite, exp.isMem, exp.aluCtrl});
        end
    endtask

    // Holds the operation on the input until the queue takes it
    task automatic sendOp(decodedOp_t op);
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        @(negedge CLK);
        decodeOp    = op;
        decodeValid = 1'b1;
        while (!done) begin
            @(posedge CLK);
            if (decodeReady) begin
                done = 1'b1;
                sentOps.push_back(op);
            end else begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    otherErrors++;
                    $display("Decode input not accepted within %0d cycles", WAIT_LIMIT);
                    done = 1'b1;
                end
            end
        end
    endtask

    task automatic idleInput();
        @(negedge CLK);
        decodeValid = 1'b0;
    endtask

    task automatic waitOutputs(int total, string what);
        int waited;
        waited = 0;
        while (issueGot.size() + lsqGot.size() < total && waited < WAIT_LIMIT) begin
            @(posedge CLK);
            waited++;
        end
        if (issueGot.size() + lsqGot.size() < total) begin
            otherErrors++;
            $display("Timed out waiting for %s outputs", what);
        end
    endtask

    task automatic checkTable();
        int iIdx;
        int lIdx;
        iIdx = 0;
        lIdx = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (tblMem[i] && lIdx < lsqGot.size()) begin
                checkOp("lsqOp", lsqGot[lIdx], tblExp[i]);
            end else if (!tblMem[i] && iIdx < issueGot.size()) begin
                checkOp("issueOp", issueGot[iIdx], tblExp[i]);
            end else begin
                otherErrors++;
                $display("Directed row %0d missing on its expected port", i);
            end
            if (tblMem[i]) begin
                lIdx++;
            end else begin
                iIdx++;
            end
        end
    endtask

    // Replays every accepted operation through the model, per port in order
    task automatic verifyAll();
        int         iIdx;
        int         lIdx;
        renamedOp_t exp;
        iIdx = 0;
        lIdx = 0;
        foreach (sentOps[k]) begin
            exp = modelRename(sentOps[k]);
            if (sentOps[k].isMem && lIdx < lsqGot.size()) begin
                checkOp("lsqOp", lsqGot[lIdx], exp);
            end else if (!sentOps[k].isMem && iIdx < issueGot.size()) begin
                checkOp("issueOp", issueGot[iIdx], exp);
            end else begin
                otherErrors++;
                $display("Operation with tag %h never came out", exp.tag);
            end
            if (sentOps[k].isMem) begin
                lIdx++;
            end else begin
                iIdx++;
            end
        end
        if (iIdx != issueGot.size() || lIdx != lsqGot.size()) begin
            otherErrors++;
            $display("Output count differs from the number of accepted operations");
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        void'($urandom(18380));
        arstN       = 1'b0;
        decodeOp    = '0;
        decodeValid = 1'b0;
        issueReady  = 1'b1;
        lsqReady    = 1'b1;
        retireValid = 1'b0;
        retirePhys  = '0;
        randMode    = 1'b0;
        valueErrors = 0;
        otherErrors = 0;
        modelTag    = '0;
        for (int i = 0; i < `RN_NUM_ARCH; i++) begin
            modelMap[i] = physReg_t'(i);
        end
        for (int i = `RN_NUM_ARCH; i < `RN_NUM_PHYS; i++) begin
            modelFree.push_back(physReg_t'(i));
        end

        setRow(0, mkDec(1, 2, 3, 1, 0, 'h0A), 0, mkRen(1, 2, 32, 3, 1, 0, 'h0A, 0));
        setRow(1, mkDec(3, 4, 5, 1, 0, 'h0B), 0, mkRen(32, 4, 33, 5, 1, 0, 'h0B, 1));
        setRow(2, mkDec(0, 5, 0, 1, 0, 'h0C), 0, mkRen(0, 33, 0, 0, 1, 0, 'h0C, 2));
        setRow(3, mkDec(3, 0, 6, 1, 1, 'h10), 1, mkRen(32, 0, 34, 6, 1, 1, 'h10, 3));
        setRow(4, mkDec(6, 5, 0, 0, 1, 'h11), 1, mkRen(34, 33, 0, 0, 0, 1, 'h11, 4));
        setRow(5, mkDec(3, 3, 3, 1, 0, 'h0D), 0, mkRen(32, 32, 35, 32, 1, 0, 'h0D, 5));
        setRow(6, mkDec(7, 8, 9, 0, 0, 'h0E), 0, mkRen(7, 8, 9, 9, 0, 0, 'h0E, 6));
        setRow(7, mkDec(3, 9, 10, 1, 0, 'h0F), 0, mkRen(35, 9, 36, 10, 1, 0, 'h0F, 7));

        repeat (8) @(posedge CLK);
        @(negedge CLK);
        arstN = 1'b1;
        if (decodeReady !== 1'b1 || issueValid !== 1'b0 || lsqValid !== 1'b0) begin
            otherErrors++;
            $display("Unexpected handshake levels after reset");
        end

        // Directed rows with both ports always ready
        for (int i = 0; i < NUM_ROWS; i++) begin
            sendOp(tblOp[i]);
        end
        idleInput();
        waitOutputs(NUM_ROWS, "directed");
        checkTable();

        // Use up the free list, the last write must stall
        for (int i = 0; i < NUM_FILL; i++) begin
            sendOp(mkDec((i % 5) + 1, (i % 9) + 2, (i % 31) + 1, 1, 0, i));
        end
        idleInput();
        waitOutputs(NUM_ROWS + NUM_FILL - 1, "allocation");
        repeat (20) @(posedge CLK);
        if (issueGot.size() + lsqGot.size() != NUM_ROWS + NUM_FILL - 1) begin
            otherErrors++;
            $display("Operation renamed while the free list was empty");
        end

        // Retire three registers and expect them back in that order
        base = issueGot.size();
        for (int k = 0; k < 3 && retirePool.size() > 0; k++) begin
            manualRetire.push_back(retirePool.pop_front());
        end
        sendOp(mkDec(1, 2, 11, 1, 0, 'h20));
        sendOp(mkDec(11, 2, 12, 1, 0, 'h21));
        idleInput();
        waitOutputs(NUM_ROWS + NUM_FILL + 2, "retire");
        for (int k = 0; k < 3; k++) begin
            if (base + k < issueGot.size() && k < retired.size()) begin
                checkPhys("issueOp.dst", issueGot[base + k].dst, retired[k]);
            end else begin
                otherErrors++;
                $display("Missing output after retire, slot %0d", k);
            end
        end

        // Random operations under back-pressure and random retires
        randMode = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = decodedOp_t'($urandom);
            sendOp(rnd);
        end
        idleInput();
        waitOutputs(NUM_ROWS + NUM_FILL + 2 + NUM_RANDOM, "random");
        randMode = 1'b0;
        repeat (5) @(posedge CLK);

        verifyAll();
        $display("Summary: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
regPkg.sv
uopPkg.sv
opQueue.sv
freeList.sv
frat.sv
renameCtrl.sv
renameTop.sv
renameTop_assert.sv
renameTop_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module renameTop_tb -f vlog.f -o renameTop_sim

./obj_dir/renameTop_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
else
    exit 1
fi
